/* dram_defines.svh */
`ifndef DRAM_DEFINES_SVH
`define DRAM_DEFINES_SVH

// Data path
`define DRAM_DATA_W 32

// Request queue slots as a power of two
`define DRAM_QUEUE_DEPTH 8

// Array geometry
`define DRAM_BANKS 4
`define DRAM_ROW_W 4
`define DRAM_COL_W 3

// Cycles from RD command to returned data
`define DRAM_RD_LAT 2

`endif

/* dram_types_pkg.sv */
`include "dram_defines.svh"

package dram_types_pkg;

    // Address fields
    typedef logic [$clog2(`DRAM_BANKS) - 1:0] bank_t;
    typedef logic [`DRAM_ROW_W - 1:0] row_t;
    typedef logic [`DRAM_COL_W - 1:0] col_t;

    typedef logic [`DRAM_DATA_W - 1:0] data_t;

    // Packed as {write, bank, row, col, data}
    typedef logic [1 + $bits(bank_t) + $bits(row_t) + $bits(col_t) + $bits(data_t) - 1:0] req_t;

    // Queue slot index
    typedef logic [$clog2(`DRAM_QUEUE_DEPTH) - 1:0] qptr_t;

endpackage

/* dram_cmd_pkg.sv */
`include "dram_defines.svh"

package dram_cmd_pkg;

    // Command pins encoding
    typedef enum logic [2:0] {
        NOP = 3'd0,
        ACT = 3'd1,
        PRE = 3'd2,
        RD  = 3'd3,
        WR  = 3'd4
    } dram_cmd_e;

    // Each state names the command currently on the bus
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        PRECHARGE = 2'd1,
        ACTIVATE  = 2'd2,
        ACCESS    = 2'd3
    } sched_state_e;

endpackage

/* dram_req_if.sv */
`timescale 1ns/100ps

interface dram_req_if
    import dram_types_pkg::*;
();

    req_t head_req;
    logic head_valid;
    logic head_aged;
    logic empty;
    logic retire;

    modport queue (
        output head_req,
        output head_valid,
        output head_aged,
        output empty,
        input  retire
    );

    modport sched (
        input  head_req,
        input  head_valid,
        input  head_aged,
        input  empty,
        output retire
    );

endinterface

/* dram_fifo.sv */
`timescale 1ns/100ps

module dram_fifo
    import dram_types_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic enqueue_en,
    input  req_t enqueue_data,
    output logic full,

    dram_req_if.queue q
);

    localparam int DEPTH = 1 << $bits(qptr_t);

    req_t ram [DEPTH];
    logic [DEPTH - 1:0] valid;
    logic [DEPTH - 1:0] ages;
    qptr_t head;
    qptr_t tail;
    logic push;

    // Zeroed ring for simulation
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            ram[i] = '0;
        end
    end

    // Enqueue while full is dropped
    assign push = enqueue_en && !full;

    always_ff @(posedge clk) begin : tail_update
        if (reset) begin
            tail <= '0;
        end else if (push) begin
            tail <= tail + 1'b1;
        end
    end

    always_ff @(posedge clk) begin : ram_write
        if (push) begin
            ram[tail] <= enqueue_data;
        end
    end

    always_ff @(posedge clk) begin : head_update
        if (reset) begin
            head <= '0;
        end else if (q.retire) begin
            head <= head + 1'b1;
        end
    end

    always_ff @(posedge clk) begin : valid_update
        if (reset) begin
            valid <= '0;
        end else begin
            if (q.retire) begin
                valid[head] <= 1'b0;
            end
            if (push) begin
                valid[tail] <= 1'b1;
            end
        end
    end

    // A slot ages one cycle after its write, wherever it sits in the ring
    always_ff @(posedge clk) begin : age_update
        if (reset) begin
            ages <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (push && tail == qptr_t'(i)) begin
                    ages[i] <= 1'b0;
                end else if (valid[i]) begin
                    ages[i] <= 1'b1;
                end
            end
        end
    end

    assign q.head_req   = ram[head];
    assign q.head_valid = valid[head];
    assign q.head_aged  = ages[head];
    assign q.empty      = ~|valid;
    assign full         = &valid;

    assert property (@(posedge clk) disable iff (reset) enqueue_en |-> !full)
        else $error("dram_fifo: enqueue while full");

    assert property (@(posedge clk) disable iff (reset) q.retire |-> q.head_valid)
        else $error("dram_fifo: retire on invalid head");

endmodule

/* dram_sched.sv */
`timescale 1ns/100ps

module dram_sched
    import dram_types_pkg::*;
    import dram_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    dram_req_if.sched s,

    output dram_cmd_e cmd_code,
    output bank_t     cmd_bank,
    output row_t      cmd_row,
    output col_t      cmd_col,
    output data_t     cmd_wdata
);

    localparam int BANKS = 1 << $bits(bank_t);

    sched_state_e state;
    logic [BANKS - 1:0] bank_open;
    row_t open_row [BANKS];

    logic hd_write;
    bank_t hd_bank;
    row_t hd_row;
    col_t hd_col;
    data_t hd_wdata;

    logic head_ready;
    logic row_hit;
    dram_cmd_e access_cmd;

    assign {hd_write, hd_bank, hd_row, hd_col, hd_wdata} = s.head_req;

    assign head_ready = !s.empty && s.head_valid && s.head_aged;
    assign row_hit    = bank_open[hd_bank] && (open_row[hd_bank] == hd_row);
    assign access_cmd = hd_write ? WR : RD;

    // Command FSM issuing one command per cycle
    always_ff @(posedge clk) begin : fsm
        if (reset) begin
            state    <= IDLE;
            cmd_code <= NOP;
            s.retire <= 1'b0;
        end else begin
            cmd_code <= NOP;
            s.retire <= 1'b0;
            case (state)
                IDLE: begin
                    if (head_ready) begin
                        if (row_hit) begin
                            cmd_code <= access_cmd;
                            s.retire <= 1'b1;
                            state    <= ACCESS;
                        end else if (bank_open[hd_bank]) begin
                            cmd_code <= PRE;
                            state    <= PRECHARGE;
                        end else begin
                            cmd_code <= ACT;
                            state    <= ACTIVATE;
                        end
                    end
                end
                PRECHARGE: begin
                    cmd_code <= ACT;
                    state    <= ACTIVATE;
                end
                ACTIVATE: begin
                    cmd_code <= access_cmd;
                    s.retire <= 1'b1;
                    state    <= ACCESS;
                end
                ACCESS: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Address and data follow the head every cycle
    always_ff @(posedge clk) begin : cmd_payload
        cmd_bank  <= hd_bank;
        cmd_row   <= hd_row;
        cmd_col   <= hd_col;
        cmd_wdata <= hd_wdata;
    end

    // Open-row table tracks what went out on the bus
    always_ff @(posedge clk) begin : open_flags
        if (reset) begin
            bank_open <= '0;
        end else if (cmd_code == PRE) begin
            bank_open[cmd_bank] <= 1'b0;
        end else if (cmd_code == ACT) begin
            bank_open[cmd_bank] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin : open_rows
        if (cmd_code == ACT) begin
            open_row[cmd_bank] <= cmd_row;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        cmd_code == ACT |-> !bank_open[cmd_bank])
        else $error("dram_sched: ACT to open bank %0d", cmd_bank);

endmodule

/* dram_array.sv */
`timescale 1ns/100ps
`include "dram_defines.svh"

module dram_array
    import dram_types_pkg::*;
    import dram_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  dram_cmd_e cmd_code,
    input  bank_t     cmd_bank,
    input  row_t      cmd_row,
    input  col_t      cmd_col,
    input  data_t     cmd_wdata,

    output logic      rd_valid,
    output data_t     rd_data
);

    localparam int LAT   = `DRAM_RD_LAT;
    localparam int WORDS = `DRAM_BANKS << (`DRAM_ROW_W + `DRAM_COL_W);

    data_t mem [WORDS];
    logic [`DRAM_BANKS - 1:0] bank_open;
    row_t act_row [`DRAM_BANKS];
    logic [$bits(bank_t) + $bits(row_t) + $bits(col_t) - 1:0] addr;
    logic [LAT - 1:0] pipe_valid;
    data_t pipe_data [LAT];

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Column access always goes to the row latched by ACT
    assign addr = {cmd_bank, act_row[cmd_bank], cmd_col};

    always_ff @(posedge clk) begin : bank_state
        if (reset) begin
            bank_open <= '0;
        end else if (cmd_code == PRE) begin
            bank_open[cmd_bank] <= 1'b0;
        end else if (cmd_code == ACT) begin
            bank_open[cmd_bank] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin : row_latch
        if (cmd_code == ACT) begin
            act_row[cmd_bank] <= cmd_row;
        end
    end

    always_ff @(posedge clk) begin : write_port
        if (cmd_code == WR && bank_open[cmd_bank]) begin
            mem[addr] <= cmd_wdata;
        end
    end

    // Read return pipeline of LAT stages
    always_ff @(posedge clk) begin : rd_valid_pipe
        if (reset) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid[0] <= (cmd_code == RD);
            for (int i = 1; i < LAT; i++) begin
                pipe_valid[i] <= pipe_valid[i - 1];
            end
        end
    end

    always_ff @(posedge clk) begin : rd_data_pipe
        pipe_data[0] <= mem[addr];
        for (int i = 1; i < LAT; i++) begin
            pipe_data[i] <= pipe_data[i - 1];
        end
    end

    assign rd_valid = pipe_valid[LAT - 1];
    assign rd_data  = pipe_data[LAT - 1];

    assert property (@(posedge clk) disable iff (reset)
        (cmd_code inside {RD, WR}) |-> bank_open[cmd_bank])
        else $error("dram_array: column access to closed bank %0d", cmd_bank);

endmodule

/* dram_sub.sv */
`timescale 1ns/100ps

module dram_sub
    import dram_types_pkg::*;
    import dram_cmd_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    input  logic      req_en,
    input  logic      req_write,
    input  bank_t     req_bank,
    input  row_t      req_row,
    input  col_t      req_col,
    input  data_t     req_wdata,
    output logic      req_full,

    output dram_cmd_e cmd_code,
    output bank_t     cmd_bank,
    output row_t      cmd_row,

    output logic      rd_valid,
    output data_t     rd_data
);

    req_t req_word;
    col_t cmd_col;
    data_t cmd_wdata;

    dram_req_if u_req_if ();

    assign req_word = {req_write, req_bank, req_row, req_col, req_wdata};

    dram_fifo u_fifo (
        .clk          (clk),
        .reset        (reset),
        .enqueue_en   (req_en),
        .enqueue_data (req_word),
        .full         (req_full),
        .q            (u_req_if.queue)
    );

    dram_sched u_sched (
        .clk       (clk),
        .reset     (reset),
        .s         (u_req_if.sched),
        .cmd_code  (cmd_code),
        .cmd_bank  (cmd_bank),
        .cmd_row   (cmd_row),
        .cmd_col   (cmd_col),
        .cmd_wdata (cmd_wdata)
    );

    dram_array u_array (
        .clk       (clk),
        .reset     (reset),
        .cmd_code  (cmd_code),
        .cmd_bank  (cmd_bank),
        .cmd_row   (cmd_row),
        .cmd_col   (cmd_col),
        .cmd_wdata (cmd_wdata),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

endmodule

/* tb_dram_sub.sv */
`timescale 1ns/100ps
`include "dram_defines.svh"

module tb_dram_sub
    import dram_types_pkg::*;
    import dram_cmd_pkg::*;
();

    localparam int MAX_REQ          = 64;
    localparam int DEPTH            = `DRAM_QUEUE_DEPTH;
    localparam int READ_STREAM_TEST = 4;
    localparam int BURST_TEST       = 5;
    localparam int WORDS            = `DRAM_BANKS << (`DRAM_ROW_W + `DRAM_COL_W);

    logic      clk;
    logic      reset;
    logic      req_en;
    logic      req_write;
    bank_t     req_bank;
    row_t      req_row;
    col_t      req_col;
    data_t     req_wdata;
    logic      req_full;
    dram_cmd_e cmd_code;
    bank_t     cmd_bank;
    row_t      cmd_row;
    logic      rd_valid;
    data_t     rd_data;

    // Requests from the input file
    int    stim_test  [MAX_REQ];
    logic  stim_write [MAX_REQ];
    bank_t stim_bank  [MAX_REQ];
    row_t  stim_row   [MAX_REQ];
    col_t  stim_col   [MAX_REQ];
    data_t stim_wdata [MAX_REQ];
    data_t stim_rdata [MAX_REQ];
    int    nreq;

    // Reference model state and expected traffic
    logic [`DRAM_BANKS - 1:0] model_open;
    row_t      model_row [`DRAM_BANKS];
    data_t     model_mem [WORDS];
    dram_cmd_e exp_code [$];
    bank_t     exp_bank [$];
    row_t      exp_row [$];
    data_t     rd_exp [$];
    int        rd_due [$];

    int   occ;
    int   cyc;
    int   timeout_limit = 200;
    int   errors;
    int   tests_run;
    int   tests_failed;
    logic full_seen;
    int   seed;

    dram_sub u_dram_sub (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin : watchdog
        cyc <= cyc + 1;
        if (cyc >= timeout_limit) begin
            $display("timeout after %0d cycles with %0d commands pending", cyc, exp_code.size());
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic load_requests();
        int    fd;
        int    t;
        int    op;
        int    b;
        int    r;
        int    c;
        data_t wd;
        data_t rdx;
        string line;
        fd = $fopen("dram_sub_input.txt", "r");
        assert (fd != 0) else begin
            $display("cannot open dram_sub_input.txt");
            errors++;
        end
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#" && nreq < MAX_REQ) begin
                    if ($sscanf(line, "%d %h %h %h %h %h %h",
                                t, op, b, r, c, wd, rdx) == 7) begin
                        stim_test[nreq]  = t;
                        stim_write[nreq] = op[0];
                        stim_bank[nreq]  = bank_t'(b);
                        stim_row[nreq]   = row_t'(r);
                        stim_col[nreq]   = col_t'(c);
                        stim_wdata[nreq] = wd;
                        stim_rdata[nreq] = rdx;
                        nreq++;
                    end
                end
            end
            $fclose(fd);
        end
        assert (nreq > 0) else begin
            $display("no requests read from the input file");
            errors++;
        end
    endtask

    function automatic void expect_cmd(input dram_cmd_e code, input bank_t bank, input row_t row);
        exp_code.push_back(code);
        exp_bank.push_back(bank);
        exp_row.push_back(row);
    endfunction

    // Open-row rule applied in request order
    function automatic void predict_request(input int idx);
        bank_t b;
        row_t  r;
        logic [$bits(bank_t) + $bits(row_t) + $bits(col_t) - 1:0] addr;
        b    = stim_bank[idx];
        r    = stim_row[idx];
        addr = {b, r, stim_col[idx]};
        if (!(model_open[b] && model_row[b] == r)) begin
            if (model_open[b]) begin
                expect_cmd(PRE, b, r);
            end
            expect_cmd(ACT, b, r);
        end
        if (stim_write[idx]) begin
            expect_cmd(WR, b, r);
            model_mem[addr] = stim_wdata[idx];
        end else begin
            expect_cmd(RD, b, r);
            rd_exp.push_back(model_mem[addr]);
            assert (stim_rdata[idx] == model_mem[addr]) else begin
                $display("mismatch expected_rdata of request %0d: file %h, model %h",
                         idx, stim_rdata[idx], model_mem[addr]);
                errors++;
            end
        end
        model_open[b] = 1'b1;
        model_row[b]  = r;
    endfunction

    task automatic send_request(input int idx);
        int gap;
        // Back-to-back tests keep the queue fed every cycle
        if (stim_test[idx] == BURST_TEST || stim_test[idx] == READ_STREAM_TEST) begin
            gap = 0;
        end else begin
            gap = $random(seed) & 3;
        end
        repeat (gap) begin
            @(posedge clk);
            req_en <= 1'b0;
        end
        @(posedge clk);
        // Hold back while the queue is full
        while (occ >= DEPTH) begin
            req_en <= 1'b0;
            @(posedge clk);
        end
        req_en    <= 1'b1;
        req_write <= stim_write[idx];
        req_bank  <= stim_bank[idx];
        req_row   <= stim_row[idx];
        req_col   <= stim_col[idx];
        req_wdata <= stim_wdata[idx];
        predict_request(idx);
    endtask

    function automatic void check_command();
        dram_cmd_e code;
        bank_t     bank;
        row_t      row;
        assert (exp_code.size() > 0) else begin
            $display("unexpected %s command on bank %0d", cmd_code.name(), cmd_bank);
            errors++;
        end
        if (exp_code.size() > 0) begin
            code = exp_code.pop_front();
            bank = exp_bank.pop_front();
            row  = exp_row.pop_front();
            assert (cmd_code == code) else begin
                $display("mismatch cmd_code: got %h, expected %h", cmd_code, code);
                errors++;
            end
            assert (cmd_bank == bank) else begin
                $display("mismatch cmd_bank: got %h, expected %h", cmd_bank, bank);
                errors++;
            end
            if (code != PRE) begin
                assert (cmd_row == row) else begin
                    $display("mismatch cmd_row: got %h, expected %h", cmd_row, row);
                    errors++;
                end
            end
        end
        if (cmd_code == RD) begin
            rd_due.push_back(cyc + `DRAM_RD_LAT);
        end
    endfunction

    function automatic void check_read();
        logic  due;
        data_t want;
        due = (rd_due.size() > 0) && (rd_due[0] == cyc) && (rd_exp.size() > 0);
        assert (due || !rd_valid) else begin
            $display("rd_valid pulsed with no read due at cycle %0d", cyc);
            errors++;
        end
        if (due) begin
            rd_due.delete(0);
            want = rd_exp.pop_front();
            assert (rd_valid) else begin
                $display("read data missing %0d cycles after RD", `DRAM_RD_LAT);
                errors++;
            end
            if (rd_valid) begin
                assert (rd_data == want) else begin
                    $display("mismatch rd_data: got %h, expected %h", rd_data, want);
                    errors++;
                end
            end
        end
    endfunction

    // Occupancy follows pushes and access commands since each access retires the head
    always @(negedge clk) begin : monitor
        if (!reset) begin
            assert (req_full == (occ == DEPTH)) else begin
                $display("mismatch req_full: got %h, expected %h", req_full, occ == DEPTH);
                errors++;
            end
            if (req_full) begin
                full_seen = 1'b1;
            end
            if (cmd_code != NOP) begin
                check_command();
            end
            check_read();
            if (req_en) begin
                occ++;
            end
            if (cmd_code == RD || cmd_code == WR) begin
                occ--;
            end
        end
    end

    task automatic report_test(input int num, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %0d passed", num);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", num, errors - err_start);
        end
    endtask

    initial begin : main
        int idx;
        int cur;
        int err_start;
        seed         = 32'h7bf0_38ba;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        occ          = 0;
        nreq         = 0;
        full_seen    = 1'b0;
        reset        = 1'b1;
        req_en       = 1'b0;
        req_write    = 1'b0;
        req_bank     = '0;
        req_row      = '0;
        req_col      = '0;
        req_wdata    = '0;
        model_open   = '0;
        for (int i = 0; i < WORDS; i++) begin
            model_mem[i] = '0;
        end
        load_requests();
        timeout_limit = 20 * nreq + 200;

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        err_start = errors;
        assert (cmd_code == NOP) else begin
            $display("mismatch cmd_code: got %h, expected %h", cmd_code, NOP);
            errors++;
        end
        assert (!rd_valid) else begin
            $display("mismatch rd_valid: got %h, expected 0", rd_valid);
            errors++;
        end
        assert (!req_full) else begin
            $display("mismatch req_full: got %h, expected 0", req_full);
            errors++;
        end
        report_test(1, err_start);

        idx = 0;
        while (idx < nreq) begin
            cur       = stim_test[idx];
            err_start = errors;
            full_seen = 1'b0;
            while (idx < nreq && stim_test[idx] == cur) begin
                send_request(idx);
                idx++;
            end
            @(posedge clk);
            req_en <= 1'b0;
            // Drain queue, commands and read returns
            while (occ != 0 || exp_code.size() != 0 ||
                   rd_due.size() != 0 || rd_exp.size() != 0) begin
                @(posedge clk);
            end
            if (cur == BURST_TEST) begin
                assert (full_seen) else begin
                    $display("req_full never rose during the back-to-back burst");
                    errors++;
                end
            end
            report_test(cur, err_start);
        end

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* dram_sub_input.txt */
# columns: test op(1=write) bank row col wdata expected_rdata, all but test in hex
# expected_rdata is only checked for reads
2 1 0 3 2 a5a50001 00000000
2 0 0 3 2 00000000 a5a50001
3 1 1 5 1 11110001 00000000
3 1 2 7 4 22220002 00000000
3 1 1 9 1 33330003 00000000
3 0 2 7 4 00000000 22220002
3 0 1 5 1 00000000 11110001
3 0 1 9 1 00000000 33330003
4 0 1 9 1 00000000 33330003
4 0 0 3 2 00000000 a5a50001
4 0 2 7 4 00000000 22220002
4 0 3 0 0 00000000 00000000
4 0 1 9 1 00000000 33330003
5 1 0 1 0 5a5a0010 00000000
5 1 0 2 0 5a5a0020 00000000
5 1 0 1 1 5a5a0011 00000000
5 1 0 2 1 5a5a0021 00000000
5 1 0 1 2 5a5a0012 00000000
5 1 0 2 2 5a5a0022 00000000
5 0 0 1 0 00000000 5a5a0010
5 0 0 2 0 00000000 5a5a0020
5 0 0 1 1 00000000 5a5a0011
5 0 0 2 1 00000000 5a5a0021
5 0 0 1 2 00000000 5a5a0012
5 0 0 2 2 00000000 5a5a0022

/* dram_sub.f */
+incdir+.
dram_types_pkg.sv
dram_cmd_pkg.sv
dram_req_if.sv
dram_fifo.sv
dram_sched.sv
dram_array.sv
dram_sub.sv
tb_dram_sub.sv

/* Bender.yml */
package:
  name: dram_sub

sources:
  - include_dirs:
      - .
    files:
      - dram_types_pkg.sv
      - dram_cmd_pkg.sv
      - dram_req_if.sv
      - dram_fifo.sv
      - dram_sched.sv
      - dram_array.sv
      - dram_sub.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dram_sub.sv
